// File: rtl/mem_pkg.sv
package mem_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Memory geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int WORD_W = 32;
    localparam int BYTE_W = 8;
    localparam int HALF_W = 2 * BYTE_W;
    localparam int ADDR_W = 32;
    localparam int LANES  = WORD_W / BYTE_W;
    localparam int DEPTH  = 256;

    // Index and byte offset widths derived from the geometry
    localparam int IDX_W  = $clog2(DEPTH);
    localparam int OFF_W  = $clog2(LANES);

    ////////////////////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [IDX_W-1:0]  widx_t;
    typedef logic [LANES-1:0]  lane_mask_t;

endpackage

// File: rtl/lsu_pkg.sv
package lsu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Load/store access codes
    ////////////////////////////////////////////////////////////////////////////

    localparam int CODE_W = 3;

    // Same encoding as the RISC-V funct3 field
    typedef logic [CODE_W-1:0] size_op_t;

    // Signed byte, halfword and full word
    localparam size_op_t OP_B  = 3'b000;
    localparam size_op_t OP_H  = 3'b001;
    localparam size_op_t OP_W  = 3'b010;

    // Unsigned byte and halfword, loads only
    localparam size_op_t OP_BU = 3'b100;
    localparam size_op_t OP_HU = 3'b101;

    // Codes 011, 110 and 111 are undefined

endpackage

// File: rtl/access_steer.sv
`timescale 1ns/10ps

module access_steer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        st_en,
    input  logic                        ld_en,
    input  lsu_pkg::size_op_t           op,
    input  mem_pkg::addr_t              addr,
    input  mem_pkg::word_t              wdata,
    output mem_pkg::widx_t              word_idx,
    output mem_pkg::lane_mask_t         lane_we,
    output mem_pkg::word_t              lane_wdata,
    output logic                        ld_go,
    output logic [mem_pkg::OFF_W-1:0]   byte_off,
    output logic                        fault
);
    import mem_pkg::*;
    import lsu_pkg::*;

    lane_mask_t size_mask;
    logic       aligned;
    logic       st_code_ok;
    logic       st_legal;
    logic       ld_req;
    logic       ld_legal;

    ////////////////////////////////////////////////////////////////////////////
    // Size and alignment decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op)
            OP_B, OP_BU: begin
                size_mask = 4'b0001;
                aligned   = 1'b1;
            end
            OP_H, OP_HU: begin
                size_mask = 4'b0011;
                aligned   = ~addr[0];
            end
            OP_W: begin
                size_mask = 4'b1111;
                aligned   = (addr[OFF_W-1:0] == '0);
            end
            // Undefined codes never pass
            default: begin
                size_mask = '0;
                aligned   = 1'b0;
            end
        endcase
    end

    // Stores only take the signed codes
    assign st_code_ok = (op == OP_B) || (op == OP_H) || (op == OP_W);
    assign st_legal   = st_en & st_code_ok & aligned;

    // Store wins when both strobes are up
    assign ld_req     = ld_en & ~st_en;
    assign ld_legal   = ld_req & aligned;

    assign word_idx   = addr[IDX_W+OFF_W-1:OFF_W];
    assign byte_off   = addr[OFF_W-1:0];
    assign ld_go      = ld_legal;
    assign lane_we    = st_legal ? lane_mask_t'(size_mask << byte_off) : '0;

    // Replicate the low store bytes into every lane they may land in
    always_comb begin
        case (op)
            OP_B:    lane_wdata = {LANES{wdata[BYTE_W-1:0]}};
            OP_H:    lane_wdata = {(LANES/2){wdata[HALF_W-1:0]}};
            default: lane_wdata = wdata;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fault <= 1'b0;
        end else begin
            fault <= (st_en & ~st_legal) | (ld_req & ~ld_legal);
        end
    end

endmodule

// File: rtl/byte_bank.sv
`timescale 1ns/10ps

module byte_bank (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            we,
    input  mem_pkg::widx_t  idx,
    input  mem_pkg::byte_t  wbyte,
    output mem_pkg::byte_t  rbyte
);
    import mem_pkg::*;

    byte_t mem [DEPTH];

    // Contents start cleared
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Synchronous write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wbyte;
        end
    end

    // Registered read, returns the byte held before any write this edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rbyte <= '0;
        end else begin
            rbyte <= mem[idx];
        end
    end

endmodule

// File: rtl/load_extend.sv
`timescale 1ns/10ps

module load_extend (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        ld_go,
    input  lsu_pkg::size_op_t           op,
    input  logic [mem_pkg::OFF_W-1:0]   byte_off,
    input  mem_pkg::word_t              lane_rdata,
    output mem_pkg::word_t              ld_data,
    output logic                        ld_valid
);
    import mem_pkg::*;
    import lsu_pkg::*;

    size_op_t          op_q;
    logic [OFF_W-1:0]  off_q;
    word_t             shifted;
    word_t             extended;

    ////////////////////////////////////////////////////////////////////////////
    // Request stage aligned with the bank read
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld_valid <= 1'b0;
            op_q     <= OP_W;
            off_q    <= '0;
        end else begin
            ld_valid <= ld_go;
            op_q     <= op;
            off_q    <= byte_off;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Byte select and extension
    ////////////////////////////////////////////////////////////////////////////

    // Addressed byte or halfword moved down to bit 0
    assign shifted = lane_rdata >> {off_q, 3'b000};

    always_comb begin
        case (op_q)
            OP_B: begin
                extended = {{(WORD_W-BYTE_W){shifted[BYTE_W-1]}}, shifted[BYTE_W-1:0]};
            end
            OP_BU: begin
                extended = {{(WORD_W-BYTE_W){1'b0}}, shifted[BYTE_W-1:0]};
            end
            OP_H: begin
                extended = {{(WORD_W-HALF_W){shifted[HALF_W-1]}}, shifted[HALF_W-1:0]};
            end
            OP_HU: begin
                extended = {{(WORD_W-HALF_W){1'b0}}, shifted[HALF_W-1:0]};
            end
            // Full word passes through
            default: begin
                extended = shifted;
            end
        endcase
    end

    // Bus stays quiet between results
    assign ld_data = ld_valid ? extended : '0;

endmodule

// File: rtl/data_mem_top.sv
`timescale 1ns/10ps

module data_mem_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                st_en,
    input  logic                ld_en,
    input  lsu_pkg::size_op_t   op,
    input  mem_pkg::addr_t      addr,
    input  mem_pkg::word_t      wdata,
    output mem_pkg::word_t      ld_data,
    output logic                ld_valid,
    output logic                fault
);
    import mem_pkg::*;

    widx_t              word_idx;
    lane_mask_t         lane_we;
    word_t              lane_wdata;
    word_t              lane_rdata;
    logic               ld_go;
    logic [OFF_W-1:0]   byte_off;

    access_steer u_steer (
        .clk        (clk),
        .rst_n      (rst_n),
        .st_en      (st_en),
        .ld_en      (ld_en),
        .op         (op),
        .addr       (addr),
        .wdata      (wdata),
        .word_idx   (word_idx),
        .lane_we    (lane_we),
        .lane_wdata (lane_wdata),
        .ld_go      (ld_go),
        .byte_off   (byte_off),
        .fault      (fault)
    );

    ////////////////////////////////////////////////////////////////////////////
    // One bank per byte lane
    ////////////////////////////////////////////////////////////////////////////

    for (genvar g = 0; g < LANES; g++) begin : g_lane
        byte_bank u_bank (
            .clk   (clk),
            .rst_n (rst_n),
            .we    (lane_we[g]),
            .idx   (word_idx),
            .wbyte (lane_wdata[g*BYTE_W +: BYTE_W]),
            .rbyte (lane_rdata[g*BYTE_W +: BYTE_W])
        );
    end

    load_extend u_extend (
        .clk        (clk),
        .rst_n      (rst_n),
        .ld_go      (ld_go),
        .op         (op),
        .byte_off   (byte_off),
        .lane_rdata (lane_rdata),
        .ld_data    (ld_data),
        .ld_valid   (ld_valid)
    );

endmodule

// File: bench/data_mem_chk.sv
`timescale 1ns/10ps

module data_mem_chk (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                st_en,
    input  logic                ld_en,
    input  lsu_pkg::size_op_t   op,
    input  mem_pkg::addr_t      addr,
    input  logic                ld_valid,
    input  logic                fault
);
    logic st_ok;
    logic ld_ok;
    logic ld_legal;
    logic refused;

    // funct3 legality per access direction
    always_comb begin
        case (op)
            3'b000:  {st_ok, ld_ok} = 2'b11;
            3'b001:  {st_ok, ld_ok} = {2{~addr[0]}};
            3'b010:  {st_ok, ld_ok} = {2{addr[1:0] == 2'b00}};
            3'b100:  {st_ok, ld_ok} = 2'b01;
            3'b101:  {st_ok, ld_ok} = {1'b0, ~addr[0]};
            default: {st_ok, ld_ok} = 2'b00;
        endcase
    end

    assign ld_legal = ld_en & ~st_en & ld_ok;
    assign refused  = (st_en & ~st_ok) | (ld_en & ~st_en & ~ld_ok);

    a_valid_after_load: assert property (@(posedge clk) disable iff (!rst_n)
        ld_legal |=> ld_valid) else $error("ld_valid missing after a legal load");
    a_valid_only_load: assert property (@(posedge clk) disable iff (!rst_n)
        !ld_legal |=> !ld_valid) else $error("ld_valid without a legal load");
    a_fault_after_refusal: assert property (@(posedge clk) disable iff (!rst_n)
        refused |=> fault) else $error("fault missing after a refused access");
    a_fault_only_refusal: assert property (@(posedge clk) disable iff (!rst_n)
        !refused |=> !fault) else $error("fault without a refused access");
    a_valid_fault_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(ld_valid && fault)) else $error("ld_valid and fault high together");
    a_quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> (!ld_valid && !fault)) else $error("outputs active during reset");

endmodule

bind data_mem_top data_mem_chk u_chk (.*);

// File: bench/data_mem_tb.sv
`timescale 1ns/10ps

module data_mem_tb;
    import mem_pkg::*;

    localparam int PERIOD_NS    = 40;
    localparam int RESET_CYCLES = 10;
    // Cycles per test, in the order the tests run
    localparam int TEST_CYCLES  = 11 + 14 + 10 + 14 + 10 + 201;
    localparam int MARGIN       = 100;

    // RISC-V funct3 access codes
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       st_en;
    logic       ld_en;
    logic [2:0] op;
    addr_t      addr;
    word_t      wdata;
    word_t      ld_data;
    logic       ld_valid;
    logic       fault;

    // Byte-wide reference copy of the memory
    byte_t ref_mem [LANES*DEPTH];

    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    int test_start_errors;

    data_mem_top dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .st_en    (st_en),
        .ld_en    (ld_en),
        .op       (op),
        .addr     (addr),
        .wdata    (wdata),
        .ld_data  (ld_data),
        .ld_valid (ld_valid),
        .fault    (fault)
    );

    always #(PERIOD_NS/2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic access_ok(input logic is_store, input logic [2:0] code,
                                       input addr_t a);
        case (code)
            F3_B:    return 1'b1;
            F3_H:    return ~a[0];
            F3_W:    return a[1:0] == 2'b00;
            F3_BU:   return ~is_store;
            F3_HU:   return ~is_store & ~a[0];
            default: return 1'b0;
        endcase
    endfunction

    function automatic word_t model_load(input logic [2:0] code, input addr_t a);
        logic [9:0] base;
        byte_t      lo;
        byte_t      hi;
        base = a[9:0];
        lo   = ref_mem[base];
        hi   = ref_mem[base | 10'd1];
        case (code)
            F3_B:    return {{24{lo[7]}}, lo};
            F3_BU:   return {24'h0, lo};
            F3_H:    return {{16{hi[7]}}, hi, lo};
            F3_HU:   return {16'h0, hi, lo};
            default: return {ref_mem[base | 10'd3], ref_mem[base | 10'd2], hi, lo};
        endcase
    endfunction

    task automatic model_store(input logic [2:0] code, input addr_t a, input word_t d);
        int n;
        n = (code == F3_B) ? 1 : (code == F3_H) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            ref_mem[a[9:0] + 10'(i)] = d[8*i +: 8];
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Drive and check
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // One access per cycle, result checked at the next falling edge
    task automatic step(input logic st, input logic ld, input logic [2:0] code,
                        input addr_t a, input word_t d);
        logic  legal;
        logic  exp_valid;
        logic  exp_fault;
        word_t exp_data;
        legal     = access_ok(st, code, a);
        exp_valid = ld & ~st & legal;
        exp_fault = (st | ld) & ~legal;
        exp_data  = exp_valid ? model_load(code, a) : '0;
        st_en = st;
        ld_en = ld;
        op    = code;
        addr  = a;
        wdata = d;
        @(negedge clk);
        check_value("ld_valid", 32'(ld_valid), 32'(exp_valid));
        check_value("fault", 32'(fault), 32'(exp_fault));
        check_value("ld_data", ld_data, exp_data);
        if (st && legal) begin
            model_store(code, a, d);
        end
    endtask

    task automatic store(input logic [2:0] code, input addr_t a, input word_t d);
        step(1'b1, 1'b0, code, a, d);
    endtask

    task automatic load(input logic [2:0] code, input addr_t a);
        step(1'b0, 1'b1, code, a, '0);
    endtask

    task automatic idle();
        step(1'b0, 1'b0, F3_B, '0, '0);
    endtask

    task automatic begin_test();
        test_start_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, errors - test_start_errors);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_word_access();
        begin_test();
        store(F3_W, 32'h0000_0000, 32'hdead_beef);
        store(F3_W, 32'h0000_0104, 32'h1234_5678);
        store(F3_W, 32'h0000_03fc, 32'hcafe_f00d);
        // Index wraps, lands on word 4
        store(F3_W, 32'h0000_0410, 32'h0bad_cafe);
        idle();
        load(F3_W, 32'h0000_0000);
        idle();
        load(F3_W, 32'h0000_0104);
        load(F3_W, 32'hffff_fffc);
        load(F3_W, 32'h0000_0010);
        idle();
        end_test("word_access");
    endtask

    task automatic test_byte_access();
        begin_test();
        store(F3_B, 32'h0000_0020, 32'hffff_ff81);
        store(F3_B, 32'h0000_0021, 32'h0000_007f);
        store(F3_B, 32'h0000_0022, 32'h1234_56c3);
        store(F3_B, 32'h0000_0023, 32'h0000_0024);
        load(F3_W, 32'h0000_0020);
        for (int i = 0; i < 4; i++) begin
            load(F3_B, 32'h0000_0020 + i);
            load(F3_BU, 32'h0000_0020 + i);
        end
        idle();
        end_test("byte_access");
    endtask

    task automatic test_half_access();
        begin_test();
        store(F3_W, 32'h0000_0040, 32'h1111_1111);
        store(F3_H, 32'h0000_0040, 32'hffff_8765);
        load(F3_W, 32'h0000_0040);
        store(F3_H, 32'h0000_0042, 32'h0000_7abc);
        load(F3_W, 32'h0000_0040);
        load(F3_H, 32'h0000_0040);
        load(F3_HU, 32'h0000_0040);
        load(F3_H, 32'h0000_0042);
        load(F3_HU, 32'h0000_0042);
        idle();
        end_test("half_access");
    endtask

    task automatic test_faults();
        begin_test();
        store(F3_W, 32'h0000_0060, 32'h5a5a_a5a5);
        store(F3_H, 32'h0000_0061, 32'hffff_ffff);
        idle();
        store(F3_W, 32'h0000_0062, 32'hffff_ffff);
        store(F3_BU, 32'h0000_0060, 32'hffff_ffff);
        store(F3_HU, 32'h0000_0060, 32'hffff_ffff);
        store(3'b011, 32'h0000_0060, 32'hffff_ffff);
        load(F3_H, 32'h0000_0063);
        load(F3_W, 32'h0000_0061);
        load(3'b011, 32'h0000_0060);
        load(3'b110, 32'h0000_0060);
        load(3'b111, 32'h0000_0060);
        idle();
        load(F3_W, 32'h0000_0060);
        end_test("faults");
    endtask

    task automatic test_back_to_back();
        begin_test();
        load(F3_W, 32'h0000_0000);
        load(F3_W, 32'h0000_0104);
        load(F3_B, 32'h0000_0020);
        store(F3_W, 32'h0000_0080, 32'h8765_4321);
        load(F3_W, 32'h0000_0080);
        store(F3_B, 32'h0000_0081, 32'h0000_00e7);
        load(F3_BU, 32'h0000_0081);
        // Both strobes high, the store goes through
        step(1'b1, 1'b1, F3_W, 32'h0000_0084, 32'h0f0f_f0f0);
        load(F3_W, 32'h0000_0084);
        idle();
        end_test("back_to_back");
    endtask

    function automatic logic [2:0] pick_code();
        case ($urandom_range(4, 0))
            0:       return F3_B;
            1:       return F3_H;
            2:       return F3_W;
            3:       return F3_BU;
            default: return F3_HU;
        endcase
    endfunction

    task automatic test_random();
        logic [2:0] code;
        addr_t      a;
        begin_test();
        for (int i = 0; i < 200; i++) begin
            code = pick_code();
            a    = $urandom;
            if (code == F3_H || code == F3_HU) begin
                a[0] = 1'b0;
            end
            if (code == F3_W) begin
                a[1:0] = 2'b00;
            end
            if ($urandom_range(1, 0) == 1 && code != F3_BU && code != F3_HU) begin
                store(code, a, $urandom);
            end else begin
                load(code, a);
            end
        end
        idle();
        end_test("random");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(21));
        rst_n        = 1'b0;
        st_en        = 1'b0;
        ld_en        = 1'b0;
        op           = F3_B;
        addr         = '0;
        wdata        = '0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < LANES*DEPTH; i++) begin
            ref_mem[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        test_word_access();
        test_byte_access();
        test_half_access();
        test_faults();
        test_back_to_back();
        test_random();
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #((RESET_CYCLES + TEST_CYCLES + MARGIN) * PERIOD_NS);
        $display("Timeout: the tests did not finish within the expected run time");
        $display("Regression failed");
        $finish;
    end

endmodule

// File: files.f
rtl/mem_pkg.sv
rtl/lsu_pkg.sv
rtl/access_steer.sv
rtl/byte_bank.sv
rtl/load_extend.sv
rtl/data_mem_top.sv
bench/data_mem_chk.sv
bench/data_mem_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the data memory testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -j 0 \
    --top-module data_mem_tb \
    -f files.f \
    -o data_mem_sim

./obj_dir/data_mem_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "Regression passed" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
